// ==== design/fpu_pkg.sv ====
package fpu_pkg;

  // ------------------------------
  // widths of the single format
  // ------------------------------
  typedef logic [31:0]        float_t;
  typedef logic [7:0]         exp_t;
  typedef logic [23:0]        mant_t;
  typedef logic signed [25:0] wide_mant_t;
  typedef logic [7:0]         bus_byte_t;
  typedef logic [3:0]         reg_addr_t;

  localparam int     EXP_BIAS = 127;
  localparam int     MANT_W   = 24;
  localparam float_t ONE_F    = {1'b0, 8'd127, 23'd0};

  // ------------------------------
  // register map
  // ------------------------------
  localparam reg_addr_t ADDR_A0 = 4'd0;
  localparam reg_addr_t ADDR_A1 = 4'd1;
  localparam reg_addr_t ADDR_A2 = 4'd2;
  localparam reg_addr_t ADDR_A3 = 4'd3;
  localparam reg_addr_t ADDR_B0 = 4'd4;
  localparam reg_addr_t ADDR_B1 = 4'd5;
  localparam reg_addr_t ADDR_B2 = 4'd6;
  localparam reg_addr_t ADDR_B3 = 4'd7;
  localparam reg_addr_t ADDR_OP = 4'd8;
  localparam reg_addr_t ADDR_R0 = 4'd9;
  localparam reg_addr_t ADDR_R1 = 4'd10;
  localparam reg_addr_t ADDR_R2 = 4'd11;
  localparam reg_addr_t ADDR_R3 = 4'd12;

  typedef enum logic [3:0] {op_add = 4'd0, op_sub = 4'd1, op_mul = 4'd2} fpu_op_e;

  typedef enum logic [1:0] {ctrl_idle, ctrl_run, ctrl_finish, ctrl_wait_ack} ctrl_state_e;

  typedef enum logic [2:0] {
    arith_idle, arith_addsub, arith_mul, arith_mul_done, arith_result
  } arith_state_e;

  typedef enum logic [2:0] {
    mul_idle, mul_load, mul_add, mul_shift, mul_set, mul_valid
  } mul_state_e;

endpackage

// ==== design/fpu_operand_if.sv ====
interface fpu_operand_if;
  import fpu_pkg::*;

  float_t  operand_a;
  float_t  operand_b;
  fpu_op_e operation;
  float_t  result;

  // register block side
  modport regs_mp (
    output operand_a, operand_b, operation,
    input  result
  );

  // arithmetic side
  modport arith_mp (
    input  operand_a, operand_b, operation,
    output result
  );
endinterface

// ==== design/fpu_regs.sv ====
module fpu_regs (
  input  logic               clk,
  input  logic               arst,
  input  logic               cs,
  input  logic               rd,
  input  logic               wr,
  input  fpu_pkg::reg_addr_t addr,
  input  fpu_pkg::bus_byte_t databus_in,
  output fpu_pkg::bus_byte_t databus_out,
  input  logic               result_load,
  output logic               op_strobe,
  fpu_operand_if.regs_mp     ops
);
  import fpu_pkg::*;

  logic wr_en;

  assign wr_en = !cs && !wr;

  // ------------------------------
  // byte writes and result load
  // ------------------------------
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      ops.operand_a <= ONE_F;
      ops.operand_b <= ONE_F;
      ops.operation <= op_add;
      op_strobe     <= 1'b0;
    end else begin
      op_strobe <= wr_en && (addr == ADDR_OP);
      if (wr_en) begin
        case (addr)
          ADDR_A0: ops.operand_a[7:0]   <= databus_in;
          ADDR_A1: ops.operand_a[15:8]  <= databus_in;
          ADDR_A2: ops.operand_a[23:16] <= databus_in;
          ADDR_A3: ops.operand_a[31:24] <= databus_in;
          ADDR_B0: ops.operand_b[7:0]   <= databus_in;
          ADDR_B1: ops.operand_b[15:8]  <= databus_in;
          ADDR_B2: ops.operand_b[23:16] <= databus_in;
          ADDR_B3: ops.operand_b[31:24] <= databus_in;
          ADDR_OP: ops.operation        <= fpu_op_e'(databus_in[3:0]);
          default: ;
        endcase
      end
      // chaining: the result becomes the next A
      if (result_load) begin
        ops.operand_a <= ops.result;
      end
    end
  end

  // readback, zero when not selected
  always_comb begin
    databus_out = '0;
    if (!cs && !rd) begin
      case (addr)
        ADDR_A0: databus_out = ops.operand_a[7:0];
        ADDR_A1: databus_out = ops.operand_a[15:8];
        ADDR_A2: databus_out = ops.operand_a[23:16];
        ADDR_A3: databus_out = ops.operand_a[31:24];
        ADDR_B0: databus_out = ops.operand_b[7:0];
        ADDR_B1: databus_out = ops.operand_b[15:8];
        ADDR_B2: databus_out = ops.operand_b[23:16];
        ADDR_B3: databus_out = ops.operand_b[31:24];
        ADDR_OP: databus_out = {4'b0000, ops.operation};
        ADDR_R0: databus_out = ops.result[7:0];
        ADDR_R1: databus_out = ops.result[15:8];
        ADDR_R2: databus_out = ops.result[23:16];
        ADDR_R3: databus_out = ops.result[31:24];
        default: databus_out = '0;
      endcase
    end
  end

  // a command start never lands on the result load
  assert property (@(posedge clk) disable iff (arst) op_strobe |=> !result_load);

endmodule

// ==== design/fpu_control.sv ====
module fpu_control (
  input  logic clk,
  input  logic arst,
  input  logic op_strobe,
  input  logic done,
  input  logic end_ack,
  output logic start,
  output logic result_load,
  output logic busy,
  output logic cmd_end
);
  import fpu_pkg::*;

  ctrl_state_e state;
  ctrl_state_e next_state;

  always_comb begin
    next_state = state;
    case (state)
      ctrl_idle:
        if (op_strobe) next_state = ctrl_run;
      ctrl_run:
        if (done) next_state = ctrl_finish;
      ctrl_finish:
        if (!done) next_state = ctrl_wait_ack;
      ctrl_wait_ack:
        if (end_ack) next_state = ctrl_idle;
      default:
        next_state = ctrl_idle;
    endcase
  end

  // outputs registered from the next state
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state       <= ctrl_idle;
      start       <= 1'b0;
      result_load <= 1'b0;
      busy        <= 1'b0;
      cmd_end     <= 1'b0;
    end else begin
      state       <= next_state;
      start       <= (next_state == ctrl_run);
      busy        <= (next_state != ctrl_idle);
      cmd_end     <= (next_state == ctrl_wait_ack);
      // one pulse as the worker reports done
      result_load <= (state == ctrl_run) && (next_state == ctrl_finish);
    end
  end

  assert property (@(posedge clk) disable iff (arst) cmd_end |-> busy);

endmodule

// ==== design/fpu_addsub.sv ====
module fpu_addsub (
  input  fpu_pkg::float_t operand_a,
  input  fpu_pkg::float_t operand_b,
  input  logic            subtract,
  output fpu_pkg::float_t sum
);
  import fpu_pkg::*;

  exp_t       exp_a;
  exp_t       exp_b;
  exp_t       exp_big;
  exp_t       exp_res;
  logic       a_zero;
  logic       b_zero;
  logic       sign_b;
  mant_t      mant_a;
  mant_t      mant_b;
  mant_t      al_a;
  mant_t      al_b;
  wide_mant_t val_a;
  wide_mant_t val_b;
  wide_mant_t total;
  logic [25:0] mag;
  logic [25:0] norm;
  logic [4:0]  lead;

  assign exp_a  = operand_a[30:23];
  assign exp_b  = operand_b[30:23];
  assign a_zero = (exp_a == '0);
  assign b_zero = (exp_b == '0);
  assign mant_a = a_zero ? '0 : {1'b1, operand_a[22:0]};
  assign mant_b = b_zero ? '0 : {1'b1, operand_b[22:0]};
  assign sign_b = operand_b[31] ^ subtract;

  // ------------------------------
  // align to the larger exponent
  // ------------------------------
  always_comb begin
    al_a    = mant_a;
    al_b    = mant_b;
    exp_big = exp_a;
    if (a_zero) begin
      exp_big = exp_b;
    end else if (!b_zero) begin
      if (exp_a >= exp_b) begin
        al_b = mant_b >> (exp_a - exp_b);
      end else begin
        exp_big = exp_b;
        al_a    = mant_a >> (exp_b - exp_a);
      end
    end
  end

  // two's complement add
  assign val_a = operand_a[31] ? -wide_mant_t'({2'b00, al_a}) : wide_mant_t'({2'b00, al_a});
  assign val_b = sign_b ? -wide_mant_t'({2'b00, al_b}) : wide_mant_t'({2'b00, al_b});
  assign total = val_a + val_b;
  assign mag   = total[25] ? -total : total;

  // ------------------------------
  // normalize to a one at bit 23
  // ------------------------------
  always_comb begin
    lead = '0;
    for (int i = 0; i < 26; i++) begin
      if (mag[i]) lead = 5'(i);
    end
    if (lead > 5'd23) begin
      norm = mag >> (lead - 5'd23);
    end else begin
      norm = mag << (5'd23 - lead);
    end
    exp_res = exp_t'({2'b00, exp_big} + {5'b00000, lead} - 10'd23);
    sum     = (total == '0) ? '0 : {total[25], exp_res, norm[22:0]};
  end

endmodule

// ==== design/fpu_mul.sv ====
module fpu_mul (
  input  logic            clk,
  input  logic            arst,
  input  logic            mul_start,
  output logic            mul_done,
  input  fpu_pkg::float_t operand_a,
  input  fpu_pkg::float_t operand_b,
  output fpu_pkg::float_t product
);
  import fpu_pkg::*;

  mul_state_e  state;
  mul_state_e  next_state;
  mant_t       multiplicand;
  logic [48:0] prod_mult;   // product in the top, multiplier shifts out the bottom
  logic [4:0]  cnt;
  exp_t        exp_a;
  exp_t        exp_b;
  logic [9:0]  exp_sum;

  assign exp_a   = operand_a[30:23];
  assign exp_b   = operand_b[30:23];
  assign exp_sum = {2'b00, exp_a} + {2'b00, exp_b} - 10'(EXP_BIAS);

  always_comb begin
    next_state = state;
    case (state)
      mul_idle:  if (mul_start) next_state = mul_load;
      mul_load:  next_state = mul_add;
      mul_add:   next_state = mul_shift;
      mul_shift: next_state = (cnt == 5'(MANT_W)) ? mul_set : mul_add;
      mul_set:   next_state = mul_valid;
      mul_valid: if (!mul_start) next_state = mul_idle;
      default:   next_state = mul_idle;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state    <= mul_idle;
      mul_done <= 1'b0;
      cnt      <= '0;
    end else begin
      state    <= next_state;
      mul_done <= (next_state == mul_valid);
      if (state == mul_load) cnt <= '0;
      else if (state == mul_add) cnt <= cnt + 5'd1;
    end
  end

  // ------------------------------
  // shift-and-add datapath
  // ------------------------------
  always_ff @(posedge clk) begin
    case (state)
      mul_load: begin
        multiplicand <= {1'b1, operand_a[22:0]};
        prod_mult    <= {25'd0, 1'b1, operand_b[22:0]};
      end
      mul_add:
        if (prod_mult[0]) prod_mult[48:24] <= prod_mult[48:24] + {1'b0, multiplicand};
      mul_shift:
        prod_mult <= prod_mult >> 1;
      mul_set:
        if (exp_a == '0 || exp_b == '0) product <= '0;
        else if (prod_mult[47])
          product <= {operand_a[31] ^ operand_b[31], exp_t'(exp_sum + 10'd1), prod_mult[46:24]};
        else
          product <= {operand_a[31] ^ operand_b[31], exp_t'(exp_sum), prod_mult[45:23]};
      default: ;
    endcase
  end

  assert property (@(posedge clk) disable iff (arst) cnt <= 5'(MANT_W));

endmodule

// ==== design/fpu_arith.sv ====
module fpu_arith (
  input  logic clk,
  input  logic arst,
  input  logic start,
  output logic done,
  fpu_operand_if.arith_mp ops
);
  import fpu_pkg::*;

  arith_state_e state;
  arith_state_e next_state;
  float_t       sum;
  float_t       product;
  logic         sub_q;
  logic         mul_start;
  logic         mul_done;

  fpu_addsub u_addsub (
    .operand_a (ops.operand_a),
    .operand_b (ops.operand_b),
    .subtract  (sub_q),
    .sum       (sum)
  );

  fpu_mul u_mul (
    .clk       (clk),
    .arst      (arst),
    .mul_start (mul_start),
    .mul_done  (mul_done),
    .operand_a (ops.operand_a),
    .operand_b (ops.operand_b),
    .product   (product)
  );

  // unknown codes fall through to the add path
  always_comb begin
    next_state = state;
    case (state)
      arith_idle:
        if (start) next_state = (ops.operation == op_mul) ? arith_mul : arith_addsub;
      arith_addsub:
        next_state = arith_result;
      arith_mul:
        if (mul_done) next_state = arith_mul_done;
      arith_mul_done:
        if (!mul_done) next_state = arith_result;
      arith_result:
        if (!start) next_state = arith_idle;
      default:
        next_state = arith_idle;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state      <= arith_idle;
      done       <= 1'b0;
      mul_start  <= 1'b0;
      sub_q      <= 1'b0;
      ops.result <= '0;
    end else begin
      state     <= next_state;
      done      <= (next_state == arith_result);
      mul_start <= (next_state == arith_mul);
      // operation sampled at dispatch, later op writes do not disturb it
      if (state == arith_idle && start) begin
        sub_q <= (ops.operation == op_sub);
      end
      if (next_state == arith_result && state != arith_result) begin
        ops.result <= (state == arith_mul_done) ? product : sum;
      end
    end
  end

  assert property (@(posedge clk) disable iff (arst) done |-> (state == arith_result));

endmodule

// ==== design/fpu_top.sv ====
module fpu_top (
  input  logic               clk,
  input  logic               arst,
  input  fpu_pkg::bus_byte_t databus_in,
  output fpu_pkg::bus_byte_t databus_out,
  input  fpu_pkg::reg_addr_t addr,
  input  logic               cs,
  input  logic               rd,
  input  logic               wr,
  input  logic               end_ack,
  output logic               cmd_end,
  output logic               busy
);

  logic op_strobe;
  logic start;
  logic done;
  logic result_load;

  fpu_operand_if ops_if ();

  // bus side registers
  fpu_regs u_regs (
    .clk         (clk),
    .arst        (arst),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .addr        (addr),
    .databus_in  (databus_in),
    .databus_out (databus_out),
    .result_load (result_load),
    .op_strobe   (op_strobe),
    .ops         (ops_if.regs_mp)
  );

  fpu_control u_control (
    .clk         (clk),
    .arst        (arst),
    .op_strobe   (op_strobe),
    .done        (done),
    .end_ack     (end_ack),
    .start       (start),
    .result_load (result_load),
    .busy        (busy),
    .cmd_end     (cmd_end)
  );

  fpu_arith u_arith (
    .clk   (clk),
    .arst  (arst),
    .start (start),
    .done  (done),
    .ops   (ops_if.arith_mp)
  );

endmodule

// ==== tests/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD = 4
) (
  output logic clk
);

  initial clk = 1'b0;

  // free running, half period per phase
  always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== tests/tb_fpu.sv ====
module tb_fpu;
  import fpu_pkg::*;

  localparam int PERIOD  = 4;
  localparam int N_ADD   = 20;
  localparam int N_SUB   = 20;
  localparam int N_MUL   = 12;
  localparam int N_CHAIN = 8;
  localparam int TIMEOUT = (N_ADD + N_SUB + N_MUL + N_CHAIN) * 100 * PERIOD;

  logic        clk;
  logic        arst;
  logic        cs;
  logic        rd;
  logic        wr;
  logic        end_ack;
  logic        cmd_end;
  logic        busy;
  reg_addr_t   addr;
  bus_byte_t   databus_in;
  bus_byte_t   databus_out;
  logic [15:0] lfsr;
  float_t      model_a;
  float_t      model_b;
  float_t      model_result;
  logic [3:0]  model_op;

  tb_clock_gen #(.PERIOD(PERIOD)) u_clock_gen (.clk(clk));

  fpu_top u_fpu_top (
    .clk         (clk),
    .arst        (arst),
    .databus_in  (databus_in),
    .databus_out (databus_out),
    .addr        (addr),
    .cs          (cs),
    .rd          (rd),
    .wr          (wr),
    .end_ack     (end_ack),
    .cmd_end     (cmd_end),
    .busy        (busy)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] time %0t: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic float_t rand_float(input int exp_lo, input int exp_span);
    logic        sign;
    logic [7:0]  e;
    logic [22:0] frac;
    sign = (take_bits(1) != 32'd0);
    e    = 8'(exp_lo + (take_bits(8) % exp_span));
    frac = 23'(take_bits(23));
    return {sign, e, frac};
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic float_t model_addsub(input float_t a, input float_t b, input logic sub);
    int     ea;
    int     eb;
    int     e;
    longint ma;
    longint mb;
    longint s;
    logic   sign;
    ea = {24'd0, a[30:23]};
    eb = {24'd0, b[30:23]};
    ma = (ea == 0) ? 64'd0 : {40'd0, 1'b1, a[22:0]};
    mb = (eb == 0) ? 64'd0 : {40'd0, 1'b1, b[22:0]};
    if (ea == 0) begin
      e = eb;
    end else if (eb == 0) begin
      e = ea;
    end else if (ea >= eb) begin
      e  = ea;
      mb = (ea - eb >= 26) ? 64'd0 : mb >> (ea - eb);
    end else begin
      e  = eb;
      ma = (eb - ea >= 26) ? 64'd0 : ma >> (eb - ea);
    end
    if (a[31]) ma = -ma;
    if (b[31] ^ sub) mb = -mb;
    s = ma + mb;
    if (s == 0) return '0;
    sign = (s < 0);
    if (sign) s = -s;
    // leading one back to bit 23
    while (s >= 64'sd16777216) begin
      s = s >> 1;
      e++;
    end
    while (s < 64'sd8388608) begin
      s = s << 1;
      e--;
    end
    return {sign, 8'(e), 23'(s)};
  endfunction

  function automatic float_t model_mul(input float_t a, input float_t b);
    logic [47:0] p;
    int          e;
    if (a[30:23] == 8'd0 || b[30:23] == 8'd0) return '0;
    p = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
    e = {24'd0, a[30:23]} + {24'd0, b[30:23]} - EXP_BIAS;
    if (p[47]) return {a[31] ^ b[31], 8'(e + 1), p[46:24]};
    return {a[31] ^ b[31], 8'(e), p[45:23]};
  endfunction

  // ------------------------------
  // bus access
  // ------------------------------
  task automatic write_reg(input reg_addr_t a, input bus_byte_t d);
    @(posedge clk);
    #1;
    cs         = 1'b0;
    rd         = 1'b1;
    wr         = 1'b0;
    addr       = a;
    databus_in = d;
    @(posedge clk);
    #1;
    cs = 1'b1;
    wr = 1'b1;
  endtask

  // sampled mid cycle once the mux has settled
  task automatic read_reg(input reg_addr_t a, output bus_byte_t d);
    @(posedge clk);
    #1;
    cs   = 1'b0;
    rd   = 1'b0;
    wr   = 1'b1;
    addr = a;
    #1;
    d = databus_out;
  endtask

  task automatic write_word(input reg_addr_t base, input float_t w);
    for (int i = 0; i < 4; i++) write_reg(4'(base + i), w[8*i +: 8]);
  endtask

  task automatic read_word(input reg_addr_t base, output float_t w);
    bus_byte_t d;
    for (int i = 0; i < 4; i++) begin
      read_reg(4'(base + i), d);
      w[8*i +: 8] = d;
    end
  endtask

  task automatic load_operands(input float_t a, input float_t b);
    write_word(ADDR_A0, a);
    write_word(ADDR_B0, b);
    model_a = a;
    model_b = b;
  endtask

  task automatic run_operation(input fpu_op_e op, input logic extra_write);
    float_t    got;
    bus_byte_t d;
    int        cycles;
    case (op)
      op_sub:  model_result = model_addsub(model_a, model_b, 1'b1);
      op_mul:  model_result = model_mul(model_a, model_b);
      default: model_result = model_addsub(model_a, model_b, 1'b0);
    endcase
    write_reg(ADDR_OP, bus_byte_t'(op));
    model_op = op;
    cycles   = 0;
    while (busy !== 1'b1 && cycles < 2) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    check_value("busy", 32'd1, {31'd0, busy});
    // must be ignored while the command runs
    if (extra_write) write_reg(ADDR_OP, bus_byte_t'(op));
    while (cmd_end !== 1'b1) begin
      check_value("busy", 32'd1, {31'd0, busy});
      @(posedge clk);
      #1;
    end
    read_word(ADDR_R0, got);
    check_value("result", model_result, got);
    read_word(ADDR_A0, got);
    check_value("operand_a", model_result, got);
    read_reg(ADDR_OP, d);
    check_value("operation", {28'd0, model_op}, {24'd0, d});
    model_a = model_result;
    cycles  = int'(take_bits(3));
    repeat (cycles) begin
      @(posedge clk);
      #1;
      check_value("busy", 32'd1, {31'd0, busy});
      check_value("cmd_end", 32'd1, {31'd0, cmd_end});
    end
    @(posedge clk);
    #1;
    cs      = 1'b1;
    rd      = 1'b1;
    end_ack = 1'b1;
    @(posedge clk);
    #1;
    end_ack = 1'b0;
    check_value("busy", 32'd0, {31'd0, busy});
    check_value("cmd_end", 32'd0, {31'd0, cmd_end});
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    float_t    a;
    float_t    b;
    float_t    got;
    bus_byte_t d;
    fpu_op_e   op;
    lfsr         = 16'd55478;
    arst         = 1'b1;
    cs           = 1'b1;
    rd           = 1'b1;
    wr           = 1'b1;
    end_ack      = 1'b0;
    addr         = '0;
    databus_in   = '0;
    model_a      = ONE_F;
    model_b      = ONE_F;
    model_result = '0;
    model_op     = '0;
    repeat (5) @(posedge clk);
    #1;
    arst = 1'b0;

    // reset values
    check_value("busy", 32'd0, {31'd0, busy});
    check_value("cmd_end", 32'd0, {31'd0, cmd_end});
    read_word(ADDR_A0, got);
    check_value("operand_a", ONE_F, got);
    read_word(ADDR_B0, got);
    check_value("operand_b", ONE_F, got);
    for (int i = 8; i < 16; i++) begin
      read_reg(reg_addr_t'(i), d);
      check_value($sformatf("readback %0d", i), 32'd0, {24'd0, d});
    end

    // byte writes and readback
    for (int i = 0; i < 8; i++) begin
      d = bus_byte_t'(take_bits(8));
      write_reg(reg_addr_t'(i), d);
      if (i < 4) model_a[8*i +: 8] = d;
      else model_b[8*(i-4) +: 8] = d;
    end
    read_word(ADDR_A0, got);
    check_value("operand_a", model_a, got);
    read_word(ADDR_B0, got);
    check_value("operand_b", model_b, got);
    for (int i = 9; i < 16; i++) write_reg(reg_addr_t'(i), bus_byte_t'(take_bits(8)));
    // result still zero and spare addresses read zero
    for (int i = 9; i < 16; i++) begin
      read_reg(reg_addr_t'(i), d);
      check_value($sformatf("readback %0d", i), 32'd0, {24'd0, d});
    end

    for (int i = 0; i < N_ADD; i++) begin
      a = rand_float(64, 127);
      if (i % 5 == 4) b = {~a[31], a[30:0]};
      else b = rand_float(64, 127);
      load_operands(a, b);
      run_operation(op_add, 1'b0);
    end

    for (int i = 0; i < N_SUB; i++) begin
      a = rand_float(64, 127);
      case (i % 4)
        1:       b = a;
        2:       b = {~a[31], a[30:0]};
        3:       b = {a[31:23], 23'(take_bits(23))};
        default: b = rand_float(64, 127);
      endcase
      load_operands(a, b);
      run_operation(op_sub, 1'b0);
    end

    for (int i = 0; i < N_MUL; i++) begin
      a = rand_float(64, 127);
      b = rand_float(64, 127);
      if (i % 4 == 1) a[30:23] = 8'd0;
      if (i % 4 == 2) b[30:23] = 8'd0;
      load_operands(a, b);
      run_operation(op_mul, i % 2 == 1);
    end

    // chained commands where A comes from the last result
    a = rand_float(110, 35);
    write_word(ADDR_A0, a);
    model_a = a;
    for (int i = 0; i < N_CHAIN; i++) begin
      if (i % 2 == 0) begin
        b = rand_float(120, 15);
        write_word(ADDR_B0, b);
        model_b = b;
      end
      op = (i % 3 == 0) ? op_add : (i % 3 == 1) ? op_sub : op_mul;
      run_operation(op, 1'b0);
    end

    $display("All tests passed");
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: the tests did not finish within %0d time units", TIMEOUT);
    $display("Some tests failed");
    $fatal(1);
  end

endmodule

// ==== src.f ====
design/fpu_pkg.sv
design/fpu_operand_if.sv
design/fpu_regs.sv
design/fpu_control.sv
design/fpu_addsub.sv
design/fpu_mul.sv
design/fpu_arith.sv
design/fpu_top.sv
tests/tb_clock_gen.sv
tests/tb_fpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the FPU testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_fpu -o tb_fpu_sim \
  || { echo "build failed"; exit 1; }
./obj_dir/tb_fpu_sim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "Some tests failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "All tests passed" sim.log || { echo "RESULT: no pass line"; exit 1; }
echo "RESULT: PASS"
